//--- rtl/memtest_settings.svh
`ifndef MEMTEST_SETTINGS_SVH
`define MEMTEST_SETTINGS_SVH

// ==============================
// Memory port geometry
// ==============================
`define MT_WIDTH        32                // Must be a multiple of 32
`define MT_ALEN         3                 // Burst length minus one, AXI len encoding

// ==============================
// Sweep range
// ==============================
`define MT_START_ADDR   32'h0000_0000
`define MT_STOP_ADDR    32'h0000_00F0     // Last burst is the first one at or above this

`define MT_SLICE_DEPTH  2                 // Entries per register slice FIFO

// Byte stride between consecutive bursts
`define MT_BURST_BYTES  ((`MT_ALEN + 1) * (`MT_WIDTH / 8))

`endif

//--- rtl/memtest_pkg.sv
`default_nettype none
`include "memtest_settings.svh"

package memtest_pkg;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // Shared address channel for reads and writes
    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;
        logic        is_write;
    } axi_a_t;

    typedef struct packed {
        logic [`MT_WIDTH-1:0] data;
        logic                 last;
    } axi_w_t;

    typedef struct packed {
        logic [`MT_WIDTH-1:0] data;
        logic [1:0]           resp;
        logic                 last;
    } axi_r_t;

    typedef struct packed {
        logic [1:0] resp;
    } axi_b_t;

    // Tag runs from ALEN+1 on the first beat down to 1 on the last one
    function automatic logic [`MT_WIDTH-1:0] pattern_word(input logic [31:0] addr,
                                                          input logic [7:0]  tag);
        return {{(`MT_WIDTH/32){~addr[7:0]}}, {(`MT_WIDTH/32){~tag}},
                {(`MT_WIDTH/32){addr[7:0]}},  {(`MT_WIDTH/32){tag}}};
    endfunction

endpackage

`default_nettype wire

//--- rtl/chan_fifo.sv
`timescale 1ns/10ps
`default_nettype none
`include "memtest_settings.svh"

module chan_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = `MT_SLICE_DEPTH
) (
    input  wire           axi_clk,
    input  wire           rstn,
    input  wire payload_t in_pl,
    input  wire           in_valid,
    output logic          in_ready,
    output payload_t      out_pl,
    output logic          out_valid,
    input  wire           out_ready
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          push;
    logic          pop;

    assign in_ready  = (count != DEPTH);   // Occupancy only, no path from out_ready
    assign out_valid = (count != 0);
    assign out_pl    = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge axi_clk)
    begin
        if (push)
            mem[wr_ptr] <= in_pl;
    end

    always_ff @(posedge axi_clk or negedge rstn)
    begin
        if (!rstn)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + {{AW{1'b0}}, push} - {{AW{1'b0}}, pop};
        end
    end

    a_no_overflow: assert property (@(posedge axi_clk) disable iff (!rstn)
        count <= DEPTH);

    // Head entry must not move while the consumer stalls
    a_out_hold: assert property (@(posedge axi_clk) disable iff (!rstn)
        out_valid && !out_ready |=> out_valid && $stable(out_pl));

endmodule

`default_nettype wire

//--- rtl/axi_reg_slice.sv
`timescale 1ns/10ps
`default_nettype none

module axi_reg_slice (
    input  wire                      axi_clk,
    input  wire                      rstn,
    // Checker side
    input  wire memtest_pkg::axi_a_t s_a_pl,
    input  wire                      s_a_valid,
    output logic                     s_a_ready,
    input  wire memtest_pkg::axi_w_t s_w_pl,
    input  wire                      s_w_valid,
    output logic                     s_w_ready,
    output memtest_pkg::axi_r_t      s_r_pl,
    output logic                     s_r_valid,
    input  wire                      s_r_ready,
    output memtest_pkg::axi_b_t      s_b_pl,
    output logic                     s_b_valid,
    input  wire                      s_b_ready,
    // Memory side
    output memtest_pkg::axi_a_t      m_a_pl,
    output logic                     m_a_valid,
    input  wire                      m_a_ready,
    output memtest_pkg::axi_w_t      m_w_pl,
    output logic                     m_w_valid,
    input  wire                      m_w_ready,
    input  wire memtest_pkg::axi_r_t m_r_pl,
    input  wire                      m_r_valid,
    output logic                     m_r_ready,
    input  wire memtest_pkg::axi_b_t m_b_pl,
    input  wire                      m_b_valid,
    output logic                     m_b_ready
);

    // ==============================
    // Request channels, checker to memory
    // ==============================
    chan_fifo #(.payload_t(memtest_pkg::axi_a_t)) u_a_fifo (
        .axi_clk, .rstn,
        .in_pl(s_a_pl), .in_valid(s_a_valid), .in_ready(s_a_ready),
        .out_pl(m_a_pl), .out_valid(m_a_valid), .out_ready(m_a_ready));

    chan_fifo #(.payload_t(memtest_pkg::axi_w_t)) u_w_fifo (
        .axi_clk, .rstn,
        .in_pl(s_w_pl), .in_valid(s_w_valid), .in_ready(s_w_ready),
        .out_pl(m_w_pl), .out_valid(m_w_valid), .out_ready(m_w_ready));

    // ==============================
    // Response channels, memory to checker
    // ==============================
    chan_fifo #(.payload_t(memtest_pkg::axi_r_t)) u_r_fifo (
        .axi_clk, .rstn,
        .in_pl(m_r_pl), .in_valid(m_r_valid), .in_ready(m_r_ready),
        .out_pl(s_r_pl), .out_valid(s_r_valid), .out_ready(s_r_ready));

    chan_fifo #(.payload_t(memtest_pkg::axi_b_t)) u_b_fifo (
        .axi_clk, .rstn,
        .in_pl(m_b_pl), .in_valid(m_b_valid), .in_ready(m_b_ready),
        .out_pl(s_b_pl), .out_valid(s_b_valid), .out_ready(s_b_ready));

endmodule

`default_nettype wire

//--- rtl/memory_checker.sv
`timescale 1ns/10ps
`default_nettype none
`include "memtest_settings.svh"

module memory_checker (
    input  wire                      axi_clk,
    input  wire                      rstn,
    input  wire                      start,
    output memtest_pkg::axi_a_t      a_pl,
    output logic                     a_valid,
    input  wire                      a_ready,
    output memtest_pkg::axi_w_t      w_pl,
    output logic                     w_valid,
    input  wire                      w_ready,
    input  wire memtest_pkg::axi_r_t r_pl,
    input  wire                      r_valid,
    output logic                     r_ready,
    input  wire memtest_pkg::axi_b_t b_pl,
    input  wire                      b_valid,
    output logic                     b_ready,
    output logic                     done,
    output logic                     pass,
    output logic [31:0]              err_addr
);

    localparam int         BEAT_BYTES = `MT_WIDTH / 8;
    localparam logic [7:0] FIRST_TAG  = 8'(`MT_ALEN + 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_WR_ADDR,
        S_WR_DATA,
        S_WR_RESP,
        S_RD_ADDR,
        S_RD_CMP,
        S_DONE
    } state_t;

    state_t               state;
    logic [1:0]           start_sync;
    logic [31:0]          burst_addr;
    logic [31:0]          next_addr;
    logic [7:0]           beat_tag;
    logic [7:0]           beat_idx;
    logic                 last_burst;
    logic                 fail;
    logic                 rd_err;
    logic                 wr_err;
    logic [`MT_WIDTH-1:0] expect_word;

    // ==============================
    // Channel outputs
    // ==============================
    assign a_valid = (state == S_WR_ADDR) || (state == S_RD_ADDR);
    assign a_pl    = '{addr: burst_addr, len: 8'(`MT_ALEN), is_write: (state == S_WR_ADDR)};
    assign w_valid = (state == S_WR_DATA);
    assign w_pl    = '{data: expect_word, last: (beat_tag == 8'd1)};
    assign b_ready = (state == S_WR_RESP);
    assign r_ready = (state == S_RD_CMP);   // Held for the whole read burst
    assign done    = (state == S_DONE);
    assign pass    = done && !fail;

    // Same word drives write data and the read expectation
    assign expect_word = memtest_pkg::pattern_word(burst_addr, beat_tag);
    assign next_addr   = burst_addr + 32'(`MT_BURST_BYTES);
    assign last_burst  = (burst_addr >= `MT_STOP_ADDR);
    assign beat_idx    = FIRST_TAG - beat_tag;

    // A misplaced last counts as a data mismatch too
    assign rd_err = (state == S_RD_CMP) && r_valid &&
                    ((r_pl.data != expect_word) ||
                     (r_pl.resp != memtest_pkg::RESP_OKAY) ||
                     (r_pl.last != (beat_tag == 8'd1)));
    assign wr_err = (state == S_WR_RESP) && b_valid && (b_pl.resp != memtest_pkg::RESP_OKAY);

    // ==============================
    // Sweep FSM
    // ==============================
    always_ff @(posedge axi_clk or negedge rstn)
    begin
        if (!rstn)
        begin
            start_sync <= 2'b00;
            state      <= S_IDLE;
            burst_addr <= `MT_START_ADDR;
            beat_tag   <= FIRST_TAG;
            fail       <= 1'b0;
        end
        else
        begin
            start_sync <= {start_sync[0], start};
            if (rd_err || wr_err)
                fail <= 1'b1;                    // Sticky until reset
            case (state)
                S_IDLE:
                    if (start_sync[1])
                    begin
                        burst_addr <= `MT_START_ADDR;
                        state      <= S_WR_ADDR;
                    end
                S_WR_ADDR, S_RD_ADDR:
                    if (a_ready)
                    begin
                        beat_tag <= FIRST_TAG;
                        state    <= (state == S_WR_ADDR) ? S_WR_DATA : S_RD_CMP;
                    end
                S_WR_DATA:
                    if (w_ready)
                    begin
                        if (beat_tag == 8'd1)
                            state <= S_WR_RESP;
                        else
                            beat_tag <= beat_tag - 8'd1;
                    end
                S_WR_RESP:
                    if (b_valid)
                    begin
                        burst_addr <= last_burst ? `MT_START_ADDR : next_addr;
                        state      <= last_burst ? S_RD_ADDR : S_WR_ADDR;
                    end
                S_RD_CMP:
                    if (r_valid)
                    begin
                        if (beat_tag != 8'd1)
                            beat_tag <= beat_tag - 8'd1;
                        else if (last_burst)
                            state <= S_DONE;
                        else
                        begin
                            burst_addr <= next_addr;
                            state      <= S_RD_ADDR;
                        end
                    end
                S_DONE:
                    state <= S_DONE;
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    // Only the first failure is kept
    always_ff @(posedge axi_clk)
    begin
        if (!fail && rd_err)
            err_addr <= burst_addr + 32'(beat_idx) * 32'(BEAT_BYTES);
        else if (!fail && wr_err)
            err_addr <= burst_addr;
    end

    a_addr_hold: assert property (@(posedge axi_clk) disable iff (!rstn)
        a_valid && !a_ready |=> a_valid && $stable(a_pl));

endmodule

`default_nettype wire

//--- rtl/memtest_top.sv
`timescale 1ns/10ps
`default_nettype none

module memtest_top (
    input  wire                      axi_clk,
    input  wire                      rstn,
    input  wire                      start,
    output logic                     done,
    output logic                     pass,
    output logic [31:0]              err_addr,
    output memtest_pkg::axi_a_t      m_a_pl,
    output logic                     m_a_valid,
    input  wire                      m_a_ready,
    output memtest_pkg::axi_w_t      m_w_pl,
    output logic                     m_w_valid,
    input  wire                      m_w_ready,
    input  wire memtest_pkg::axi_r_t m_r_pl,
    input  wire                      m_r_valid,
    output logic                     m_r_ready,
    input  wire memtest_pkg::axi_b_t m_b_pl,
    input  wire                      m_b_valid,
    output logic                     m_b_ready
);

    // Checker to slice
    memtest_pkg::axi_a_t a_pl;
    logic                a_valid;
    logic                a_ready;
    memtest_pkg::axi_w_t w_pl;
    logic                w_valid;
    logic                w_ready;
    memtest_pkg::axi_r_t r_pl;
    logic                r_valid;
    logic                r_ready;
    memtest_pkg::axi_b_t b_pl;
    logic                b_valid;
    logic                b_ready;

    memory_checker u_checker (
        .axi_clk, .rstn, .start,
        .a_pl, .a_valid, .a_ready, .w_pl, .w_valid, .w_ready,
        .r_pl, .r_valid, .r_ready, .b_pl, .b_valid, .b_ready,
        .done, .pass, .err_addr);

    axi_reg_slice u_slice (
        .axi_clk, .rstn,
        .s_a_pl(a_pl), .s_a_valid(a_valid), .s_a_ready(a_ready),
        .s_w_pl(w_pl), .s_w_valid(w_valid), .s_w_ready(w_ready),
        .s_r_pl(r_pl), .s_r_valid(r_valid), .s_r_ready(r_ready),
        .s_b_pl(b_pl), .s_b_valid(b_valid), .s_b_ready(b_ready),
        .m_a_pl, .m_a_valid, .m_a_ready, .m_w_pl, .m_w_valid, .m_w_ready,
        .m_r_pl, .m_r_valid, .m_r_ready, .m_b_pl, .m_b_valid, .m_b_ready);

endmodule

`default_nettype wire

//--- verif/axi_mem_model.sv
`timescale 1ns/10ps
`default_nettype none
`include "memtest_settings.svh"

module axi_mem_model (
    input  wire                      axi_clk,
    input  wire                      rstn,
    input  wire [31:0]               fault_a,
    input  wire [`MT_WIDTH-1:0]      mask_a,
    input  wire [31:0]               fault_b,
    input  wire [`MT_WIDTH-1:0]      mask_b,
    input  wire [31:0]               slverr_addr,
    input  wire [31:0]               stall_pct,
    output int                       wr_bursts = 0,
    output int                       rd_bursts = 0,
    input  wire memtest_pkg::axi_a_t m_a_pl,
    input  wire                      m_a_valid,
    output logic                     m_a_ready = 1'b0,
    input  wire memtest_pkg::axi_w_t m_w_pl,
    input  wire                      m_w_valid,
    output logic                     m_w_ready = 1'b0,
    output memtest_pkg::axi_r_t      m_r_pl = '0,
    output logic                     m_r_valid = 1'b0,
    input  wire                      m_r_ready,
    output memtest_pkg::axi_b_t      m_b_pl = '0,
    output logic                     m_b_valid = 1'b0,
    input  wire                      m_b_ready
);

    localparam int BEAT_BYTES = `MT_WIDTH / 8;
    localparam int N_BURSTS   = (`MT_STOP_ADDR - `MT_START_ADDR + `MT_BURST_BYTES - 1)
                                / `MT_BURST_BYTES + 1;

    typedef enum logic [1:0] {M_IDLE, M_WRITE, M_WRESP, M_READ} mstate_t;

    logic [`MT_WIDTH-1:0] mem [256];
    mstate_t              state = M_IDLE;
    logic [31:0]          burst_addr = '0;
    logic [31:0]          beat_addr;
    logic [31:0]          next_waddr;
    logic [31:0]          next_raddr;
    int                   beat = 0;
    int                   i;
    integer               seed = 80;
    logic                 a_held = 1'b0;
    logic                 w_held = 1'b0;
    memtest_pkg::axi_a_t  a_prev;
    memtest_pkg::axi_w_t  w_prev;

    assign beat_addr = burst_addr + 32'(beat) * BEAT_BYTES;

    function automatic logic roll();
        return ($unsigned($random(seed)) % 100) >= stall_pct;   // Ready with stall odds
    endfunction

    // Four byte fields, each repeated once per 32 bits of width
    function automatic logic [`MT_WIDTH-1:0] beat_pattern(input logic [31:0] addr,
                                                          input logic [7:0]  tag);
        logic [`MT_WIDTH-1:0] word;
        int                   rep;
        int                   k;
        rep = `MT_WIDTH / 32;
        for (k = 0; k < rep; k++)
        begin
            word[k*8 +: 8]           = tag;
            word[(rep + k)*8 +: 8]   = addr[7:0];
            word[(2*rep + k)*8 +: 8] = ~tag;
            word[(3*rep + k)*8 +: 8] = ~addr[7:0];
        end
        return word;
    endfunction

    function automatic memtest_pkg::axi_r_t read_beat(input logic [31:0] addr, input int b);
        memtest_pkg::axi_r_t r;
        r.data = mem[(addr / BEAT_BYTES) % 256];
        r.resp = (addr == slverr_addr) ? 2'b10 : 2'b00;
        r.last = (b == `MT_ALEN);
        return r;
    endfunction

    // ==============================
    // Burst engine
    // ==============================
    always @(posedge axi_clk or negedge rstn)
    begin
        if (!rstn)
        begin
            for (i = 0; i < 256; i++)
                mem[i] <= {(`MT_WIDTH/32){32'(i) * 32'h9E37_79B9}};   // Distinct per word
            state      <= M_IDLE;
            m_a_ready  <= 1'b0;
            m_w_ready  <= 1'b0;
            m_r_valid  <= 1'b0;
            m_b_valid  <= 1'b0;
            wr_bursts  <= 0;
            rd_bursts  <= 0;
            next_waddr <= `MT_START_ADDR;
            next_raddr <= `MT_START_ADDR;
        end
        else
            case (state)
                M_IDLE:
                    if (m_a_valid && m_a_ready)
                    begin
                        memtest_tb.check_value("m_a_pl.len", m_a_pl.len, `MT_ALEN);
                        burst_addr <= m_a_pl.addr;
                        beat       <= 0;
                        m_a_ready  <= 1'b0;
                        if (m_a_pl.is_write)
                        begin
                            memtest_tb.check_value("m_a_pl.addr", m_a_pl.addr, next_waddr);
                            next_waddr <= next_waddr + `MT_BURST_BYTES;
                            wr_bursts  <= wr_bursts + 1;
                            m_w_ready  <= roll();
                            state      <= M_WRITE;
                        end
                        else
                        begin
                            // Reads may only start once the write sweep is complete
                            memtest_tb.check_value("wr_bursts", wr_bursts, N_BURSTS);
                            memtest_tb.check_value("m_a_pl.addr", m_a_pl.addr, next_raddr);
                            next_raddr <= next_raddr + `MT_BURST_BYTES;
                            rd_bursts  <= rd_bursts + 1;
                            m_r_pl     <= read_beat(m_a_pl.addr, 0);
                            m_r_valid  <= 1'b1;
                            state      <= M_READ;
                        end
                    end
                    else
                        m_a_ready <= roll();
                M_WRITE:
                    if (m_w_valid && m_w_ready)
                    begin
                        memtest_tb.check_value("m_w_pl.data", m_w_pl.data,
                                               beat_pattern(burst_addr, 8'(`MT_ALEN + 1 - beat)));
                        memtest_tb.check_value("m_w_pl.last", m_w_pl.last, beat == `MT_ALEN);
                        mem[(beat_addr / BEAT_BYTES) % 256] <= m_w_pl.data
                            ^ ((beat_addr == fault_a) ? mask_a : '0)
                            ^ ((beat_addr == fault_b) ? mask_b : '0);
                        beat <= beat + 1;
                        if (beat == `MT_ALEN)
                        begin
                            m_w_ready <= 1'b0;
                            m_b_valid <= 1'b1;
                            state     <= M_WRESP;
                        end
                        else
                            m_w_ready <= roll();
                    end
                    else
                        m_w_ready <= roll();
                M_WRESP:
                    if (m_b_valid && m_b_ready)
                    begin
                        m_b_valid <= 1'b0;
                        m_a_ready <= roll();
                        state     <= M_IDLE;
                    end
                default:
                    if (m_r_valid && m_r_ready)
                    begin
                        beat <= beat + 1;
                        if (beat == `MT_ALEN)
                        begin
                            m_r_valid <= 1'b0;
                            m_a_ready <= roll();
                            state     <= M_IDLE;
                        end
                        else
                            m_r_pl <= read_beat(beat_addr + BEAT_BYTES, beat + 1);
                    end
            endcase
    end

    // A stalled beat must come back unchanged on the next cycle
    always @(posedge axi_clk)
    begin
        if (rstn && a_held)
            memtest_tb.check_value("m_a_pl held", {m_a_valid, m_a_pl}, {1'b1, a_prev});
        if (rstn && w_held)
            memtest_tb.check_value("m_w_pl held", {m_w_valid, m_w_pl}, {1'b1, w_prev});
        a_held <= m_a_valid && !m_a_ready;
        w_held <= m_w_valid && !m_w_ready;
        a_prev <= m_a_pl;
        w_prev <= m_w_pl;
    end

endmodule

`default_nettype wire

//--- verif/memtest_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "memtest_settings.svh"

module memtest_tb;

    localparam int     N_BURSTS   = (`MT_STOP_ADDR - `MT_START_ADDR + `MT_BURST_BYTES - 1)
                                    / `MT_BURST_BYTES + 1;
    localparam longint TIMEOUT_NS = longint'(N_BURSTS) * (`MT_ALEN + 1) * 2 * 20 * 8;

    logic                 axi_clk;
    logic                 rstn;
    logic                 start;
    logic                 done;
    logic                 pass;
    logic [31:0]          err_addr;
    memtest_pkg::axi_a_t  m_a_pl;
    logic                 m_a_valid;
    logic                 m_a_ready;
    memtest_pkg::axi_w_t  m_w_pl;
    logic                 m_w_valid;
    logic                 m_w_ready;
    memtest_pkg::axi_r_t  m_r_pl;
    logic                 m_r_valid;
    logic                 m_r_ready;
    memtest_pkg::axi_b_t  m_b_pl;
    logic                 m_b_valid;
    logic                 m_b_ready;
    logic [31:0]          fault_a;
    logic [`MT_WIDTH-1:0] mask_a;
    logic [31:0]          fault_b;
    logic [`MT_WIDTH-1:0] mask_b;
    logic [31:0]          slverr_addr;
    logic [31:0]          stall_pct;
    int                   wr_bursts;
    int                   rd_bursts;
    logic                 running;
    time                  t0;
    int                   n_tests;

    memtest_top uut (.*);

    axi_mem_model mem_model (.*);

    initial
    begin
        axi_clk = 1'b0;
        forever
            #4 axi_clk = ~axi_clk;
    end

    task automatic check_value(input string name, input logic [`MT_WIDTH+63:0] got,
                               input logic [`MT_WIDTH+63:0] exp);
        if (got !== exp)
        begin
            $display("[FAIL] t=%0t %s got=%0h expected=%0h", $time, name, got, exp);
            $display("** FAIL **");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // ==============================
    // One test: reset, start, wait for done
    // ==============================
    task automatic run_test(input logic exp_pass, input logic [31:0] exp_err);
        @(posedge axi_clk);
        rstn <= 1'b0;
        repeat (2) @(posedge axi_clk);
        rstn <= 1'b1;
        @(posedge axi_clk);
        start <= 1'b1;
        @(posedge axi_clk);
        start   <= 1'b0;
        t0      = $time;
        running = 1'b1;
        while (!done)
            @(posedge axi_clk);
        running = 1'b0;
        check_value("pass", pass, exp_pass);
        if (!exp_pass)
            check_value("err_addr", err_addr, exp_err);   // Only defined on failure
        check_value("rd_bursts", rd_bursts, N_BURSTS);
    endtask

    initial
    begin
        int          fd;
        int          n;
        string       line;
        logic [31:0] exp_pass;
        logic [31:0] exp_err;
        rstn        = 1'b0;
        start       = 1'b0;
        fault_a     = '1;
        mask_a      = '0;
        fault_b     = '1;
        mask_b      = '0;
        slverr_addr = '1;
        stall_pct   = 0;
        running     = 1'b0;
        t0          = 0;
        n_tests     = 0;
        fd = $fopen("verif/memtest_testdata.txt", "r");
        if (fd == 0)
        begin
            $display("The test data file verif/memtest_testdata.txt could not be opened");
            $display("** FAIL **");
            $fatal(1, "No stimulus");
        end
        else
        begin
            while ($fgets(line, fd) > 0)
            begin
                n = $sscanf(line, "%h %h %h %h %h %d %d %h", fault_a, mask_a, fault_b,
                            mask_b, slverr_addr, stall_pct, exp_pass, exp_err);
                if (n == 8)   // Header and blank lines are skipped
                begin
                    run_test(exp_pass[0], exp_err);
                    n_tests++;
                end
            end
            $fclose(fd);
            if (n_tests == 0)
            begin
                $display("The test data file held no test lines");
                $display("** FAIL **");
                $fatal(1, "Empty stimulus");
            end
            else
            begin
                $display("%0d tests completed", n_tests);
                $display("** PASS **");
                $finish;
            end
        end
    end

    // Watchdog, budget per test from the sweep length
    initial
    begin
        do
            @(posedge axi_clk);
        while (!(running && ($time - t0) > TIMEOUT_NS));
        $display("Timeout: done never came within %0d ns after start", TIMEOUT_NS);
        $display("** FAIL **");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+rtl
rtl/memtest_pkg.sv
rtl/chan_fifo.sv
rtl/axi_reg_slice.sv
rtl/memory_checker.sv
rtl/memtest_top.sv
verif/axi_mem_model.sv
verif/memtest_tb.sv

//--- verif/memtest_testdata.txt
# fault_a  mask_a  fault_b  mask_b  slverr_addr  stall_pct  exp_pass  exp_err_addr
# Addresses, masks and exp_err_addr in hex, stall_pct and exp_pass in decimal, ffffffff is unused
ffffffff 00000000 ffffffff 00000000 ffffffff 0  1 00000000
ffffffff 00000000 ffffffff 00000000 ffffffff 50 1 00000000
00000044 00000100 ffffffff 00000000 ffffffff 0  0 00000044
000000a8 80000000 ffffffff 00000000 ffffffff 30 0 000000a8
000000fc ffffffff ffffffff 00000000 ffffffff 50 0 000000fc
0000009c 00000001 00000030 00010000 ffffffff 50 0 00000030
ffffffff 00000000 ffffffff 00000000 0000007c 0  0 0000007c
000000e4 00000040 ffffffff 00000000 00000020 25 0 00000020
000001f0 00ff0000 ffffffff 00000000 ffffffff 10 1 00000000
